// File: hdl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Cache geometry
`define CACHE_SETS 8
`define CACHE_WAYS 2
`define LINE_WORDS 8

// Byte address width, words are 32 bits
`define ADDR_W 32

// Address split, low to high: byte, word in line, set, tag
`define WORD_LSB 2
`define SET_LSB (`WORD_LSB + $clog2(`LINE_WORDS))
`define TAG_LSB (`SET_LSB + $clog2(`CACHE_SETS))

`endif

// File: hdl/CachePkg.sv
`default_nettype none

`include "cache_cfg.svh"

package CachePkg;

    localparam SET_W = $clog2(`CACHE_SETS);
    localparam WAY_W = $clog2(`CACHE_WAYS);
    localparam OFF_W = $clog2(`LINE_WORDS);
    localparam TAG_W = `ADDR_W - `TAG_LSB;
    localparam WORD_ADDR_W = `ADDR_W - `WORD_LSB;

    typedef enum logic [2:0] {
        OP_LOAD,
        OP_STORE,
        OP_CLEAN,
        OP_INVAL,
        OP_FLUSH
    } CacheOp;

    typedef enum logic [2:0] {
        IDLE,
        EVICT_REQ,
        EVICT_WAIT,
        FILL_REQ,
        FILL_WAIT,
        FLUSH_SCAN
    } CtrlState;

    typedef enum logic {
        COPY_TO_CACHE,
        COPY_TO_EXT
    } CopyDir;

    typedef struct packed {
        logic valid;
        CacheOp op;
        logic [`ADDR_W-1:0] addr;
        logic [31:0] wdata;
    } AccessReq;

    typedef struct packed {
        logic valid;
        logic [31:0] rdata;
    } AccessRsp;

    // Line-aligned word address on the external side
    typedef struct packed {
        CopyDir dir;
        logic [WAY_W-1:0] way;
        logic [SET_W-1:0] set;
        logic [WORD_ADDR_W-1:0] extLineAddr;
    } CopyCmd;

    typedef struct packed {
        logic en;
        logic we;
        logic [WAY_W-1:0] way;
        logic [SET_W-1:0] set;
        logic [OFF_W-1:0] word;
        logic [31:0] wdata;
    } SramPort;

    typedef struct packed {
        logic valid;
        logic write;
        logic [WORD_ADDR_W-1:0] addr;
        logic [31:0] wdata;
    } ExtReq;

    typedef struct packed {
        logic valid;
        logic [31:0] rdata;
    } ExtRsp;

endpackage

`default_nettype wire

// File: hdl/CacheController.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module CacheController (
    input wire clk,
    input wire rst,

    input wire CachePkg::AccessReq req,
    output logic stall,
    output CachePkg::AccessRsp rsp,

    input wire fence,
    output logic fenceBusy,

    output logic copyReq,
    output CachePkg::CopyCmd copyCmd,
    input wire copyAck,

    output CachePkg::SramPort ctrlPort,
    input wire [31:0] ctrlRdata
);
    import CachePkg::*;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic valid;
        logic dirty;
        logic used;
    } TagEntry;

    TagEntry tagTable [`CACHE_SETS][`CACHE_WAYS];
    CtrlState state;
    CopyCmd fillCmd;
    logic fillAfter;
    logic rspValid;
    logic [SET_W+WAY_W:0] flushIter;

    logic [TAG_W-1:0] reqTag;
    logic [SET_W-1:0] reqSet;
    logic [OFF_W-1:0] reqWord;
    assign reqTag = req.addr[`ADDR_W-1:`TAG_LSB];
    assign reqSet = req.addr[`SET_LSB +: SET_W];
    assign reqWord = req.addr[`WORD_LSB +: OFF_W];

    // Top bit of the flush counter marks the end of the scan
    logic [WAY_W-1:0] flushWay;
    logic [SET_W-1:0] flushSet;
    logic flushDone;
    assign flushWay = flushIter[WAY_W-1:0];
    assign flushSet = flushIter[WAY_W +: SET_W];
    assign flushDone = flushIter[SET_W+WAY_W];

    logic hit;
    logic freeAvail;
    logic [WAY_W-1:0] hitWay;
    logic [WAY_W-1:0] freeWay;
    logic [WAY_W-1:0] evictWay;

    always_comb begin
        hit = 1'b0;
        freeAvail = 1'b0;
        hitWay = '0;
        freeWay = '0;
        evictWay = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (tagTable[reqSet][w].valid && tagTable[reqSet][w].tag == reqTag) begin
                hit = 1'b1;
                hitWay = WAY_W'(w);
            end
            if (!tagTable[reqSet][w].valid) begin
                freeAvail = 1'b1;
                freeWay = WAY_W'(w);
            end
            // Victim is the way not touched last
            if (!tagTable[reqSet][w].used)
                evictWay = WAY_W'(w);
        end
    end

    logic hitDirty;
    logic isAccess;
    logic canAccept;
    logic accept;
    assign hitDirty = tagTable[reqSet][hitWay].dirty;
    assign isAccess = req.op == OP_LOAD || req.op == OP_STORE;

    always_comb begin
        case (req.op)
            OP_LOAD, OP_STORE: canAccept = hit;
            OP_CLEAN, OP_FLUSH: canAccept = !(hit && hitDirty);
            default: canAccept = 1'b1;
        endcase
    end

    assign stall = fence || fenceBusy || state != IDLE || (req.valid && !canAccept);
    assign accept = req.valid && !stall;

    function automatic CopyCmd makeCmd(CopyDir dir, logic [WAY_W-1:0] way,
                                       logic [SET_W-1:0] setIdx, logic [TAG_W-1:0] tag);
        CopyCmd cmd;
        cmd.dir = dir;
        cmd.way = way;
        cmd.set = setIdx;
        cmd.extLineAddr = {tag, setIdx, {OFF_W{1'b0}}};
        return cmd;
    endfunction

    always_comb begin
        ctrlPort.en = accept && isAccess;
        ctrlPort.we = req.op == OP_STORE;
        ctrlPort.way = hitWay;
        ctrlPort.set = reqSet;
        ctrlPort.word = reqWord;
        ctrlPort.wdata = req.wdata;
        rsp.valid = rspValid;
        rsp.rdata = ctrlRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            copyReq <= 1'b0;
            fillAfter <= 1'b0;
            rspValid <= 1'b0;
            fenceBusy <= 1'b0;
            flushIter <= '0;
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    tagTable[s][w].valid <= 1'b0;
                    tagTable[s][w].dirty <= 1'b0;
                    tagTable[s][w].used <= 1'b0;
                end
            end
        end else begin
            rspValid <= accept && req.op == OP_LOAD;

            if (accept) begin
                case (req.op)
                    OP_LOAD, OP_STORE: begin
                        for (int w = 0; w < `CACHE_WAYS; w++)
                            tagTable[reqSet][w].used <= WAY_W'(w) == hitWay;
                        if (req.op == OP_STORE)
                            tagTable[reqSet][hitWay].dirty <= 1'b1;
                    end
                    // Flush reaches here only once the line is clean
                    OP_INVAL, OP_FLUSH: begin
                        if (hit)
                            tagTable[reqSet][hitWay] <= '0;
                    end
                    default: ;
                endcase
            end

            case (state)
                IDLE: begin
                    if (fenceBusy) begin
                        state <= FLUSH_SCAN;
                    end else if (!fence && req.valid && isAccess && !hit) begin
                        fillCmd <= makeCmd(COPY_TO_CACHE, freeAvail ? freeWay : evictWay,
                                           reqSet, reqTag);
                        copyReq <= 1'b1;
                        if (!freeAvail && tagTable[reqSet][evictWay].dirty) begin
                            copyCmd <= makeCmd(COPY_TO_EXT, evictWay, reqSet,
                                               tagTable[reqSet][evictWay].tag);
                            fillAfter <= 1'b1;
                            state <= EVICT_REQ;
                        end else begin
                            copyCmd <= makeCmd(COPY_TO_CACHE, freeAvail ? freeWay : evictWay,
                                               reqSet, reqTag);
                            state <= FILL_REQ;
                        end
                        if (!freeAvail)
                            tagTable[reqSet][evictWay] <= '0;
                    end else if (!fence && req.valid && !isAccess && !canAccept) begin
                        // Dirty hit on clean or flush, write back first
                        copyCmd <= makeCmd(COPY_TO_EXT, hitWay, reqSet, reqTag);
                        copyReq <= 1'b1;
                        fillAfter <= 1'b0;
                        tagTable[reqSet][hitWay].dirty <= 1'b0;
                        state <= EVICT_REQ;
                    end
                end
                EVICT_REQ, FILL_REQ: begin
                    if (copyAck) begin
                        copyReq <= 1'b0;
                        state <= state == EVICT_REQ ? EVICT_WAIT : FILL_WAIT;
                    end
                end
                EVICT_WAIT: begin
                    if (!copyAck) begin
                        if (fillAfter) begin
                            copyCmd <= fillCmd;
                            copyReq <= 1'b1;
                            fillAfter <= 1'b0;
                            state <= FILL_REQ;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                FILL_WAIT: begin
                    if (!copyAck) begin
                        tagTable[copyCmd.set][copyCmd.way] <= '{
                            tag: copyCmd.extLineAddr[WORD_ADDR_W-1 -: TAG_W],
                            valid: 1'b1,
                            dirty: 1'b0,
                            used: 1'b0
                        };
                        state <= IDLE;
                    end
                end
                FLUSH_SCAN: begin
                    if (flushDone) begin
                        fenceBusy <= 1'b0;
                        state <= IDLE;
                    end else begin
                        flushIter <= flushIter + 1'b1;
                        tagTable[flushSet][flushWay] <= '0;
                        if (tagTable[flushSet][flushWay].valid &&
                            tagTable[flushSet][flushWay].dirty) begin
                            copyCmd <= makeCmd(COPY_TO_EXT, flushWay, flushSet,
                                               tagTable[flushSet][flushWay].tag);
                            copyReq <= 1'b1;
                            fillAfter <= 1'b0;
                            state <= EVICT_REQ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase

            // A new fence restarts the scan from the first line
            if (fence) begin
                fenceBusy <= 1'b1;
                flushIter <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/CacheLineSram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module CacheLineSram (
    input wire clk,

    input wire CachePkg::SramPort ctrlPort,
    output logic [31:0] ctrlRdata,

    input wire CachePkg::SramPort enginePort,
    output logic [31:0] engineRdata
);
    import CachePkg::*;

    localparam DEPTH = `CACHE_SETS * `CACHE_WAYS * `LINE_WORDS;
    localparam IDX_W = WAY_W + SET_W + OFF_W;

    logic [31:0] mem [DEPTH];

    // Each way holds its sets back to back
    function automatic logic [IDX_W-1:0] wordIndex(SramPort port);
        return {port.way, port.set, port.word};
    endfunction

    logic [IDX_W-1:0] ctrlIdx;
    logic [IDX_W-1:0] engineIdx;
    assign ctrlIdx = wordIndex(ctrlPort);
    assign engineIdx = wordIndex(enginePort);

    always_ff @(posedge clk) begin
        if (ctrlPort.en) begin
            if (ctrlPort.we)
                mem[ctrlIdx] <= ctrlPort.wdata;
            ctrlRdata <= mem[ctrlIdx];
        end
        if (enginePort.en) begin
            if (enginePort.we)
                mem[engineIdx] <= enginePort.wdata;
            engineRdata <= mem[engineIdx];
        end
    end

endmodule

`default_nettype wire

// File: hdl/LineCopyEngine.sv
`timescale 1ns/1ps
`default_nettype none

module LineCopyEngine (
    input wire clk,
    input wire rst,

    input wire copyReq,
    input wire CachePkg::CopyCmd copyCmd,
    output logic copyAck,

    output CachePkg::SramPort enginePort,
    input wire [31:0] engineRdata,

    output CachePkg::ExtReq extReq,
    input wire extReady,
    input wire CachePkg::ExtRsp extRsp
);
    import CachePkg::*;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_READ,
        ENG_WRITE,
        ENG_REQ,
        ENG_WAIT,
        ENG_ACK
    } EngState;

    EngState state;
    logic [OFF_W-1:0] wordCnt;
    logic lastWord;
    assign lastWord = &wordCnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENG_IDLE;
            wordCnt <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (copyReq) begin
                        wordCnt <= '0;
                        state <= copyCmd.dir == COPY_TO_EXT ? ENG_READ : ENG_REQ;
                    end
                end
                // SRAM data shows up the cycle after the read
                ENG_READ: state <= ENG_WRITE;
                ENG_WRITE: begin
                    if (extReady) begin
                        wordCnt <= wordCnt + 1'b1;
                        state <= lastWord ? ENG_ACK : ENG_READ;
                    end
                end
                ENG_REQ: begin
                    if (extReady)
                        state <= ENG_WAIT;
                end
                ENG_WAIT: begin
                    if (extRsp.valid) begin
                        wordCnt <= wordCnt + 1'b1;
                        state <= lastWord ? ENG_ACK : ENG_REQ;
                    end
                end
                ENG_ACK: begin
                    if (!copyReq)
                        state <= ENG_IDLE;
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    assign copyAck = state == ENG_ACK;

    always_comb begin
        extReq.valid = state == ENG_WRITE || state == ENG_REQ;
        extReq.write = state == ENG_WRITE;
        extReq.addr = {copyCmd.extLineAddr[WORD_ADDR_W-1:OFF_W], wordCnt};
        extReq.wdata = engineRdata;

        // Fill data goes straight into the line as it returns
        enginePort.en = state == ENG_READ || (state == ENG_WAIT && extRsp.valid);
        enginePort.we = state == ENG_WAIT;
        enginePort.way = copyCmd.way;
        enginePort.set = copyCmd.set;
        enginePort.word = wordCnt;
        enginePort.wdata = extRsp.rdata;
    end

endmodule

`default_nettype wire

// File: hdl/CacheSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module CacheSubsystem (
    input wire clk,
    input wire rst,

    input wire CachePkg::AccessReq req,
    output logic stall,
    output CachePkg::AccessRsp rsp,

    input wire fence,
    output logic fenceBusy,

    output CachePkg::ExtReq extReq,
    input wire extReady,
    input wire CachePkg::ExtRsp extRsp
);
    import CachePkg::*;

    logic copyReq;
    logic copyAck;
    CopyCmd copyCmd;
    SramPort ctrlPort;
    SramPort enginePort;
    logic [31:0] ctrlRdata;
    logic [31:0] engineRdata;

    CacheController i_CacheController (
        .clk(clk),
        .rst(rst),
        .req(req),
        .stall(stall),
        .rsp(rsp),
        .fence(fence),
        .fenceBusy(fenceBusy),
        .copyReq(copyReq),
        .copyCmd(copyCmd),
        .copyAck(copyAck),
        .ctrlPort(ctrlPort),
        .ctrlRdata(ctrlRdata)
    );

    CacheLineSram i_CacheLineSram (
        .clk(clk),
        .ctrlPort(ctrlPort),
        .ctrlRdata(ctrlRdata),
        .enginePort(enginePort),
        .engineRdata(engineRdata)
    );

    LineCopyEngine i_LineCopyEngine (
        .clk(clk),
        .rst(rst),
        .copyReq(copyReq),
        .copyCmd(copyCmd),
        .copyAck(copyAck),
        .enginePort(enginePort),
        .engineRdata(engineRdata),
        .extReq(extReq),
        .extReady(extReady),
        .extRsp(extRsp)
    );

endmodule

`default_nettype wire

// File: test/ExtMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module ExtMemModel #(
    parameter int WORDS = 4096,
    parameter int LOG_DEPTH = 8192,
    parameter logic [31:0] FILL = 32'h0,
    parameter int SEED = 1
) (
    input wire clk,
    input wire rst,

    input wire CachePkg::ExtReq extReq,
    output logic extReady,
    output CachePkg::ExtRsp extRsp
);
    import CachePkg::*;

    localparam IDX_W = $clog2(WORDS);

    logic [31:0] mem [WORDS];

    // Every bus beat in order, reads and writes
    logic [WORD_ADDR_W-1:0] logAddr [LOG_DEPTH];
    logic logWrite [LOG_DEPTH];
    logic [31:0] logData [LOG_DEPTH];
    int logCount;

    int seed = SEED;
    logic pending;
    int delay;
    logic [31:0] pendData;
    logic [IDX_W-1:0] idx;
    assign idx = extReq.addr[IDX_W-1:0];

    always @(posedge clk) begin
        if (rst) begin
            extReady <= 1'b0;
            extRsp <= '0;
            pending <= 1'b0;
            delay <= 0;
            logCount <= 0;
            for (int i = 0; i < WORDS; i++)
                mem[i] <= i ^ FILL;
        end else begin
            // Ready drops about one cycle in four, and while a read is out
            extReady <= !pending && ($random(seed) & 3) != 0;
            extRsp.valid <= 1'b0;
            if (extReq.valid && extReady) begin
                logAddr[logCount % LOG_DEPTH] <= extReq.addr;
                logWrite[logCount % LOG_DEPTH] <= extReq.write;
                logData[logCount % LOG_DEPTH] <= extReq.write ? extReq.wdata : mem[idx];
                logCount <= logCount + 1;
                if (extReq.write) begin
                    mem[idx] <= extReq.wdata;
                end else begin
                    pending <= 1'b1;
                    delay <= $random(seed) & 3;
                    pendData <= mem[idx];
                end
            end
            if (pending) begin
                if (delay == 0) begin
                    extRsp.valid <= 1'b1;
                    extRsp.rdata <= pendData;
                    pending <= 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/CacheSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module CacheSubsystemTb;
    import CachePkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int MEM_WORDS = 4096;
    localparam int LOG_DEPTH = 8192;
    localparam logic [31:0] MEM_FILL = 32'h6b1d0000;
    localparam int RANDOM_OPS = 300;
    localparam int FENCE_LINES = 2 * `CACHE_SETS;
    // Write-back plus fill on a slow bus
    localparam int MISS_CYCLES = 200;
    localparam int ACCESS_LIMIT = 2 * MISS_CYCLES;
    localparam int FLUSH_LIMIT = `CACHE_SETS * `CACHE_WAYS * MISS_CYCLES;
    // Fence lines count for the store, the flush and the reload
    localparam int OP_COUNT = 2 + 3 + RANDOM_OPS + 9 + 3 * FENCE_LINES;
    localparam int WATCHDOG_NS = OP_COUNT * MISS_CYCLES * 2 * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst = 1'b1;
    AccessReq req = '0;
    logic fence = 1'b0;
    logic stall;
    AccessRsp rsp;
    logic fenceBusy;
    ExtReq extReq;
    logic extReady;
    ExtRsp extRsp;

    logic [31:0] refMem [MEM_WORDS];
    int seed = 32'hc02a7c70;
    int errorCount = 0;
    int testStartErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;

    CacheSubsystem i_CacheSubsystem (
        .clk(clk),
        .rst(rst),
        .req(req),
        .stall(stall),
        .rsp(rsp),
        .fence(fence),
        .fenceBusy(fenceBusy),
        .extReq(extReq),
        .extReady(extReady),
        .extRsp(extRsp)
    );

    ExtMemModel #(
        .WORDS(MEM_WORDS),
        .LOG_DEPTH(LOG_DEPTH),
        .FILL(MEM_FILL),
        .SEED(32'hc02a7c70)
    ) i_ExtMemModel (
        .clk(clk),
        .rst(rst),
        .extReq(extReq),
        .extReady(extReady),
        .extRsp(extRsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] extInit(int idx);
        return idx ^ MEM_FILL;
    endfunction

    function automatic logic [31:0] makeAddr(int tag, int setIdx, int word);
        return (tag << `TAG_LSB) | (setIdx << `SET_LSB) | (word << `WORD_LSB);
    endfunction

    function automatic int wordIdx(logic [31:0] addr);
        return int'(addr >> `WORD_LSB);
    endfunction

    function automatic int lineBase(logic [31:0] addr);
        return wordIdx(addr) & ~(`LINE_WORDS - 1);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("[FAIL] %s: got %08h, expected %08h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkCond(input logic ok, input string what);
        assert (ok)
        else begin
            $display("Failure: %s", what);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount == testStartErrors) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: %0d failed checks", testsRun, name,
                     errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    // One request through the valid/stall handshake
    task automatic access(input CacheOp op, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
        AccessReq r;
        int waited;
        r.valid = 1'b1;
        r.op = op;
        r.addr = addr;
        r.wdata = wdata;
        waited = 0;
        @(posedge clk);
        req <= r;
        @(negedge clk);
        while (stall && waited < ACCESS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        checkCond(waited < ACCESS_LIMIT, "access port stayed stalled past the timeout");
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        checkValue("rsp.valid", 32'(rsp.valid), 32'(op == OP_LOAD));
        rdata = rsp.rdata;
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        access(OP_STORE, addr, data, unused);
        refMem[wordIdx(addr)] = data;
    endtask

    task automatic loadCheck(input logic [31:0] addr);
        logic [31:0] got;
        access(OP_LOAD, addr, 32'h0, got);
        checkValue("rsp.rdata", got, refMem[wordIdx(addr)]);
    endtask

    // Bus log entries from first on must cover the line in order
    task automatic checkLine(input int first, input logic isWrite, input logic [31:0] addr);
        int k;
        int pos;
        for (k = 0; k < `LINE_WORDS; k++) begin
            pos = (first + k) % LOG_DEPTH;
            checkValue("extReq.addr", 32'(i_ExtMemModel.logAddr[pos]), lineBase(addr) + k);
            checkValue("extReq.write", 32'(i_ExtMemModel.logWrite[pos]), 32'(isWrite));
        end
    endtask

    task automatic checkWriteBack(input int first, input logic [31:0] addr,
                                  input logic [31:0] data);
        int pos;
        checkLine(first, 1'b1, addr);
        pos = (first + wordIdx(addr) % `LINE_WORDS) % LOG_DEPTH;
        checkValue("extReq.wdata", i_ExtMemModel.logData[pos], data);
    endtask

    initial begin
        logic [31:0] addrA;
        logic [31:0] addrB;
        logic [31:0] addrC;
        logic [31:0] data;
        logic [31:0] got;
        logic [31:0] fenceAddrs [FENCE_LINES];
        int mark;
        int waited;
        int n;

        for (n = 0; n < MEM_WORDS; n++)
            refMem[n] = extInit(n);
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        checkValue("stall", 32'(stall), 0);
        checkValue("rsp.valid", 32'(rsp.valid), 0);
        checkValue("fenceBusy", 32'(fenceBusy), 0);
        checkValue("extReq.valid", 32'(extReq.valid), 0);
        finishTest("reset state");

        addrA = makeAddr(1, 0, 3);
        mark = i_ExtMemModel.logCount;
        loadCheck(addrA);
        checkValue("bus beats", i_ExtMemModel.logCount - mark, `LINE_WORDS);
        checkLine(mark, 1'b0, addrA);
        mark = i_ExtMemModel.logCount;
        loadCheck(addrA);
        checkValue("bus beats", i_ExtMemModel.logCount - mark, 0);
        finishTest("load miss then hit");

        // Three tags in set 6, A must be the victim
        addrA = makeAddr(10, 6, 2);
        addrB = makeAddr(11, 6, 5);
        addrC = makeAddr(12, 6, 0);
        data = $random(seed);
        store(addrA, data);
        loadCheck(addrB);
        mark = i_ExtMemModel.logCount;
        loadCheck(addrC);
        checkValue("bus beats", i_ExtMemModel.logCount - mark, 2 * `LINE_WORDS);
        checkWriteBack(mark, addrA, data);
        checkLine(mark + `LINE_WORDS, 1'b0, addrC);
        finishTest("dirty eviction");

        for (n = 0; n < RANDOM_OPS; n++) begin
            addrA = makeAddr($random(seed) & 3, $random(seed) & 3,
                             $random(seed) & (`LINE_WORDS - 1));
            if ($random(seed) & 1)
                store(addrA, $random(seed));
            else
                loadCheck(addrA);
        end
        finishTest("random traffic");

        // Clean keeps the line cached
        addrA = makeAddr(20, 7, 1);
        data = $random(seed);
        store(addrA, data);
        mark = i_ExtMemModel.logCount;
        access(OP_CLEAN, addrA, 32'h0, got);
        checkValue("bus beats", i_ExtMemModel.logCount - mark, `LINE_WORDS);
        checkWriteBack(mark, addrA, data);
        mark = i_ExtMemModel.logCount;
        loadCheck(addrA);
        checkValue("bus beats", i_ExtMemModel.logCount - mark, 0);

        // Inval loses the store
        addrB = makeAddr(21, 7, 4);
        store(addrB, $random(seed));
        mark = i_ExtMemModel.logCount;
        access(OP_INVAL, addrB, 32'h0, got);
        checkValue("bus beats", i_ExtMemModel.logCount - mark, 0);
        refMem[wordIdx(addrB)] = extInit(wordIdx(addrB));
        loadCheck(addrB);
        checkValue("bus beats", i_ExtMemModel.logCount - mark, `LINE_WORDS);
        checkLine(mark, 1'b0, addrB);

        addrC = makeAddr(22, 7, 6);
        data = $random(seed);
        store(addrC, data);
        mark = i_ExtMemModel.logCount;
        access(OP_FLUSH, addrC, 32'h0, got);
        checkValue("bus beats", i_ExtMemModel.logCount - mark, `LINE_WORDS);
        checkWriteBack(mark, addrC, data);
        mark = i_ExtMemModel.logCount;
        loadCheck(addrC);
        checkValue("bus beats", i_ExtMemModel.logCount - mark, `LINE_WORDS);
        checkLine(mark, 1'b0, addrC);
        finishTest("maintenance ops");

        // Two dirty lines in every set
        for (n = 0; n < FENCE_LINES; n++) begin
            fenceAddrs[n] = makeAddr(40 + n / `CACHE_SETS, n % `CACHE_SETS,
                                     $random(seed) & (`LINE_WORDS - 1));
            store(fenceAddrs[n], $random(seed));
        end
        @(posedge clk);
        fence <= 1'b1;
        @(posedge clk);
        fence <= 1'b0;
        @(negedge clk);
        checkValue("fenceBusy", 32'(fenceBusy), 1);
        waited = 0;
        while (fenceBusy && waited < FLUSH_LIMIT) begin
            checkValue("stall", 32'(stall), 1);
            @(negedge clk);
            waited++;
        end
        checkCond(!fenceBusy, "fence flush did not finish before the timeout");
        for (n = 0; n < MEM_WORDS; n++)
            checkValue($sformatf("ext mem[%0d]", n), i_ExtMemModel.mem[n], refMem[n]);
        for (n = 0; n < FENCE_LINES; n++) begin
            mark = i_ExtMemModel.logCount;
            loadCheck(fenceAddrs[n]);
            checkValue("bus beats", i_ExtMemModel.logCount - mark, `LINE_WORDS);
            checkLine(mark, 1'b0, fenceAddrs[n]);
        end
        finishTest("fence flush");

        $display("%0d tests, %0d failed, %0d failed checks", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run took longer than all tests allow");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/CachePkg.sv
hdl/CacheController.sv
hdl/CacheLineSram.sv
hdl/LineCopyEngine.sv
hdl/CacheSubsystem.sv
test/ExtMemModel.sv
test/CacheSubsystemTb.sv

// File: Makefile
TOP = CacheSubsystemTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module CacheSubsystem -f verilog.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TEST PASS" sim.log
	@! grep -q "TEST FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
